// File: rtl/sergpio_pkg.sv
// shared sizes and types for the serial gpio bridge; one 4-bit gpio slot, 8N1 only, no parity
package sergpio_pkg;

    localparam int gpio_width     = 4;  // pins in the single slot
    localparam int data_width     = 8;  // serial byte
    localparam int reg_addr_width = 4;  // cmd byte bits 3:0
    localparam int os_div         = 4;  // clocks per oversample tick
    localparam int os_per_bit     = 16; // ticks per bit, so 64 clocks per bit

    // register map, anything else reads zero
    typedef enum logic [reg_addr_width-1:0] {
        reg_dir   = 4'd0, // 1 = pin driven
        reg_out   = 4'd1,
        reg_in    = 4'd2, // synchronized pin value, read only
        reg_isr   = 4'd3, // change status, write 1 to clear
        reg_imask = 4'd4
    } reg_addr_e;

    typedef enum logic [1:0] {
        st_cmd,   // waiting for command byte
        st_data,  // write data byte expected
        st_reply  // read data pending on txd
    } cmd_state_e;

    // shared by rx and tx
    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_bits,
        st_stop
    } uart_state_e;

    typedef struct packed {
        logic                  wr;    // one-cycle write strobe
        logic                  rd;    // one-cycle read strobe
        reg_addr_e             addr;
        logic [data_width-1:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic [gpio_width-1:0] out_en;
        logic [gpio_width-1:0] out;
    } gpio_drive_t;

endpackage

// File: rtl/baud_timer.sv
// free-running oversample tick, one clk wide every os_div clocks; no phase alignment to the line
`timescale 1ns/1ps

module baud_timer import sergpio_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    output logic os_tick // 16x bit rate
);

    localparam int cnt_width = (os_div > 1) ? $clog2(os_div) : 1;

    logic [cnt_width-1:0] cnt_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q   <= '0;
            os_tick <= 1'b0;
        end else begin
            // wrap at os_div-1
            if (cnt_q == cnt_width'(os_div - 1)) begin
                cnt_q   <= '0;
                os_tick <= 1'b1;
            end else begin
                cnt_q   <= cnt_q + 1'b1;
                os_tick <= 1'b0;
            end
        end
    end

endmodule

// File: rtl/uart_rx.sv
// 8N1 receiver, mid-bit sampling on the 16x tick; bad stop bit silently drops the frame, no back-pressure
`timescale 1ns/1ps

module uart_rx import sergpio_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  os_tick,
    input  logic                  rxd,
    output logic [data_width-1:0] rx_data,
    output logic                  rx_valid // one clk, mid stop bit
);

    uart_state_e                     state_q;
    logic                            rxd_meta, rxd_s;   // 2-flop sync
    logic [$clog2(os_per_bit)-1:0]   tick_cnt;
    logic [$clog2(data_width)-1:0]   bit_cnt;
    logic [data_width-1:0]           shift_q;

    // line idles high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;
            rxd_s    <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_s    <= rxd_meta;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= st_idle;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state_q)
                st_idle: if (!rxd_s) begin // falling start edge
                    state_q  <= st_start;
                    tick_cnt <= '0;
                end
                st_start: if (os_tick) begin
                    tick_cnt <= tick_cnt + 1'b1;
                    // half a bit in, start must still be low
                    if (tick_cnt == os_per_bit / 2 - 1) begin
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        state_q  <= rxd_s ? st_idle : st_bits; // glitch, back to idle
                    end
                end
                st_bits: if (os_tick) begin
                    tick_cnt <= tick_cnt + 1'b1; // wraps to 0 after 16
                    if (tick_cnt == os_per_bit - 1) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == data_width - 1)
                            state_q <= st_stop;
                    end
                end
                st_stop: if (os_tick) begin
                    tick_cnt <= tick_cnt + 1'b1;
                    if (tick_cnt == os_per_bit - 1) begin
                        rx_valid <= rxd_s; // stop low = framing error, dropped
                        state_q  <= st_idle;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // data path, lsb first into the top end
    always_ff @(posedge clk) begin
        if (state_q == st_bits && os_tick && tick_cnt == os_per_bit - 1)
            shift_q <= {rxd_s, shift_q[data_width-1:1]};
        if (state_q == st_stop && os_tick && tick_cnt == os_per_bit - 1 && rxd_s)
            rx_data <= shift_q;
    end

endmodule

// File: rtl/uart_tx.sv
// 8N1 transmitter, one frame per tx_start; tx_start while busy is ignored
`timescale 1ns/1ps

module uart_tx import sergpio_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  os_tick,
    input  logic                  tx_start,
    input  logic [data_width-1:0] tx_data,
    output logic                  txd,
    output logic                  tx_busy
);

    uart_state_e                     state_q;
    logic [$clog2(os_per_bit)-1:0]   tick_cnt;
    logic [$clog2(data_width)-1:0]   bit_cnt;
    logic [data_width-1:0]           shift_q;
    logic                            bit_end;

    assign bit_end = os_tick && (tick_cnt == os_per_bit - 1); // last tick of a bit
    assign tx_busy = tx_start || (state_q != st_idle);         // high from the strobe on

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= st_idle;
            txd      <= 1'b1; // idle mark
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            if (state_q != st_idle && os_tick)
                tick_cnt <= tick_cnt + 1'b1;
            case (state_q)
                st_idle: if (tx_start) begin
                    txd      <= 1'b0; // start bit right away
                    tick_cnt <= '0;
                    state_q  <= st_start;
                end
                st_start: if (bit_end) begin
                    txd     <= shift_q[0];
                    bit_cnt <= '0;
                    state_q <= st_bits;
                end
                st_bits: if (bit_end) begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == data_width - 1) begin
                        txd     <= 1'b1; // stop
                        state_q <= st_stop;
                    end else begin
                        txd <= shift_q[0];
                    end
                end
                st_stop: if (bit_end)
                    state_q <= st_idle;
                default: state_q <= st_idle;
            endcase
        end
    end

    // payload shifter
    always_ff @(posedge clk) begin
        if (state_q == st_idle && tx_start)
            shift_q <= tx_data;
        else if ((state_q == st_start || state_q == st_bits) && bit_end)
            shift_q <= shift_q >> 1; // next bit to [0]
    end

endmodule

// File: rtl/serial_cmd_fsm.sv
// command parser; bit 7 set = write (addr byte then data byte), clear = read with one reply byte
`timescale 1ns/1ps

module serial_cmd_fsm import sergpio_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [data_width-1:0] rx_data,
    input  logic                  rx_valid,
    input  logic                  tx_busy,
    input  logic [data_width-1:0] rdata,
    output reg_req_t              req,
    output logic [data_width-1:0] tx_data,
    output logic                  tx_start
);

    cmd_state_e state_q;
    reg_addr_e  addr_q;   // write address held between the two bytes
    logic       is_write;

    assign is_write = rx_data[data_width-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= st_cmd;
            addr_q   <= reg_dir;
            req      <= '0;
            tx_start <= 1'b0;
        end else begin
            // strobes last one cycle
            req.wr   <= 1'b0;
            req.rd   <= 1'b0;
            tx_start <= 1'b0;
            case (state_q)
                st_cmd: if (rx_valid) begin
                    if (is_write) begin
                        addr_q  <= reg_addr_e'(rx_data[reg_addr_width-1:0]);
                        state_q <= st_data;
                    end else begin
                        req.rd   <= 1'b1; // rdata comes back this next cycle
                        req.addr <= reg_addr_e'(rx_data[reg_addr_width-1:0]);
                        state_q  <= st_reply;
                    end
                end
                st_data: if (rx_valid) begin
                    req.wr    <= 1'b1;
                    req.addr  <= addr_q;
                    req.wdata <= rx_data;
                    state_q   <= st_cmd;
                end
                st_reply: begin
                    // bytes arriving here are dropped, host waits for the reply
                    if (!tx_busy) begin
                        tx_start <= 1'b1;
                        state_q  <= st_cmd;
                    end
                end
                default: state_q <= st_cmd;
            endcase
        end
    end

    // capture read data during the read strobe
    always_ff @(posedge clk) begin
        if (req.rd)
            tx_data <= rdata;
    end

endmodule

// File: rtl/gpio_regs.sv
// gpio slot registers; pads assumed pulled up, so the input synchronizer resets to all ones
`timescale 1ns/1ps

module gpio_regs import sergpio_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  reg_req_t              req,
    output logic [data_width-1:0] rdata,
    input  logic [gpio_width-1:0] gpio_in,
    output gpio_drive_t           pins,
    output logic                  intr
);

    logic [gpio_width-1:0] dir_q, out_q, isr_q, imask_q;
    logic [gpio_width-1:0] in_meta, in_sync, in_prev;
    logic [gpio_width-1:0] chg, isr_clr;

    assign chg     = in_sync ^ in_prev; // any edge on a synced bit
    assign isr_clr = (req.wr && req.addr == reg_isr) ? req.wdata[gpio_width-1:0] : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_meta <= '1;
            in_sync <= '1;
            in_prev <= '1;
        end else begin
            in_meta <= gpio_in;
            in_sync <= in_meta;
            in_prev <= in_sync; // for change detect
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dir_q   <= '0; // all inputs
            out_q   <= '0;
            imask_q <= '0;
            isr_q   <= '0;
        end else begin
            if (req.wr) begin
                case (req.addr)
                    reg_dir:   dir_q   <= req.wdata[gpio_width-1:0];
                    reg_out:   out_q   <= req.wdata[gpio_width-1:0];
                    reg_imask: imask_q <= req.wdata[gpio_width-1:0];
                    default: ; // isr handled below, rest ignored
                endcase
            end
            isr_q <= (isr_q & ~isr_clr) | chg; // new change beats the clear
        end
    end

    // read mux, zero extended, unmapped reads zero
    always_comb begin
        rdata = '0;
        if (req.rd) begin
            case (req.addr)
                reg_dir:   rdata[gpio_width-1:0] = dir_q;
                reg_out:   rdata[gpio_width-1:0] = out_q;
                reg_in:    rdata[gpio_width-1:0] = in_sync;
                reg_isr:   rdata[gpio_width-1:0] = isr_q;
                reg_imask: rdata[gpio_width-1:0] = imask_q;
                default:   rdata = '0;
            endcase
        end
    end

    assign pins.out_en = dir_q;
    assign pins.out    = out_q;
    assign intr        = |(isr_q & imask_q);

endmodule

// File: rtl/serial_gpio_top.sv
// bridge top without pads or pll; pins leave as separate enable/out/in vectors, pad modelled outside
`timescale 1ns/1ps

module serial_gpio_top import sergpio_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  rxd,
    output logic                  txd,
    output logic                  intr,
    output logic [gpio_width-1:0] gpio_out_en,
    output logic [gpio_width-1:0] gpio_out,
    input  logic [gpio_width-1:0] gpio_in
);

    logic                  os_tick;
    logic [data_width-1:0] rx_data, tx_data, rdata;
    logic                  rx_valid, tx_start, tx_busy;
    reg_req_t              req;
    gpio_drive_t           pins;

    baud_timer timer_i (.clk, .rst_n, .os_tick);

    uart_rx rx_i (.clk, .rst_n, .os_tick, .rxd, .rx_data, .rx_valid);

    uart_tx tx_i (.clk, .rst_n, .os_tick, .tx_start, .tx_data, .txd, .tx_busy);

    serial_cmd_fsm cmd_i (
        .clk, .rst_n, .rx_data, .rx_valid, .tx_busy, .rdata, .req, .tx_data, .tx_start
    );

    gpio_regs regs_i (.clk, .rst_n, .req, .rdata, .gpio_in, .pins, .intr);

    assign gpio_out_en = pins.out_en;
    assign gpio_out    = pins.out;

endmodule

// File: testbench/tb_clk_gen.sv
// free-running testbench clock, 40 ns period, starts low at time zero
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk
);

    localparam realtime half_period = 20ns; // 25 MHz

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

endmodule

// File: testbench/serial_gpio_chk.sv
// bound into serial_gpio_top; needs the internal tx_busy and the register request bus req
`timescale 1ns/1ps

module serial_gpio_chk import sergpio_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input logic     txd,
    input logic     tx_busy,
    input logic     intr,
    input reg_req_t req
);

    logic mask_zero_q; // mask as last written on the bus

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            mask_zero_q <= 1'b1; // mask comes out of reset as zero
        else if (req.wr && req.addr == reg_imask)
            mask_zero_q <= (req.wdata[gpio_width-1:0] == '0);
    end

    // idle transmitter keeps the line at mark
    property idle_line_high;
        @(posedge clk) disable iff (!rst_n) !tx_busy |-> txd;
    endproperty

    // masked-off status can never reach intr
    property no_intr_when_masked;
        @(posedge clk) disable iff (!rst_n) mask_zero_q |-> !intr;
    endproperty

    idle_line_a: assert property (idle_line_high)
        else $error("txd went low while the transmitter was idle");

    intr_mask_a: assert property (no_intr_when_masked)
        else $error("intr high with the interrupt mask all zero");

endmodule

// File: testbench/serial_gpio_tb.sv
// reads testbench/serial_gpio_stimulus.txt from the run directory; pads pulled up, one reply per read
`timescale 1ns/1ps

module serial_gpio_tb import sergpio_pkg::*; ();

    localparam int bit_clks    = os_div * os_per_bit; // 64 clocks per serial bit
    localparam int frame_clks  = 10 * bit_clks;       // 8N1 frame
    localparam int settle_clks = 8;                   // sync + change detect + status

    logic                  clk, rst_n, rxd, txd, intr, loaded;
    logic [gpio_width-1:0] gpio_out_en, gpio_out, gpio_in;
    logic [gpio_width-1:0] ext_in;         // what the outside world drives
    logic [gpio_width-1:0] sh_dir, sh_out; // expected dir/out from the writes sent
    logic [7:0]            op_q[$], a_q[$], b_q[$];
    int                    script_len, check_errors, other_errors, seed;

    tb_clk_gen clk_i (.clk(clk));

    serial_gpio_top dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .rxd        (rxd),
        .txd        (txd),
        .intr       (intr),
        .gpio_out_en(gpio_out_en),
        .gpio_out   (gpio_out),
        .gpio_in    (gpio_in)
    );

    bind serial_gpio_top serial_gpio_chk chk_i (
        .clk(clk), .rst_n(rst_n), .txd(txd), .tx_busy(tx_busy), .intr(intr),
        .req(req)
    );

    // driven bits follow the dut and the rest take the outside value
    assign gpio_in = (gpio_out_en & gpio_out) | (~gpio_out_en & ext_in);

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s expected %h, got %h",
                     $time, name, expected, actual);
            check_errors++;
        end
    endtask

    task automatic send_byte(input logic [7:0] data);
        logic [9:0] frame;
        int         i;
        frame = {1'b1, data, 1'b0}; // stop, data lsb first, start
        for (i = 0; i < 10; i++) begin
            @(negedge clk);
            rxd = frame[i];
            repeat (bit_clks - 1) @(negedge clk);
        end
    endtask

    task automatic recv_byte(input logic [3:0] addr, output logic [7:0] data, output logic ok);
        int waited;
        int i;
        waited = 0;
        ok     = 1'b0;
        data   = '0;
        while (txd !== 1'b0 && waited < 3 * frame_clks) begin
            @(negedge clk);
            waited++;
        end
        if (txd === 1'b0) begin
            repeat (bit_clks / 2) @(negedge clk); // middle of start bit
            for (i = 0; i < 8; i++) begin
                repeat (bit_clks) @(negedge clk);
                data[i] = txd;
            end
            repeat (bit_clks) @(negedge clk);
            ok = (txd === 1'b1);
            if (!ok) begin
                $display("reply to the read of register %h had a low stop bit", addr);
                other_errors++;
            end
        end else begin
            $display("reply to the read of register %h never started", addr);
            other_errors++;
        end
    endtask

    task automatic read_reg(input logic [3:0] addr, output logic [7:0] data, output logic ok);
        // reply starts while our stop bit is still on the line
        fork
            send_byte({4'b0000, addr});
            recv_byte(addr, data, ok);
        join
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [7:0] data);
        send_byte({4'b1000, addr});
        send_byte(data);
        if (addr == reg_dir)
            sh_dir = data[gpio_width-1:0];
        if (addr == reg_out)
            sh_out = data[gpio_width-1:0];
    endtask

    task automatic run_line(input int line_no, input logic [7:0] op,
                            input logic [7:0] a, input logic [7:0] b);
        logic [7:0]            rd;
        logic                  ok;
        logic [31:0]           rnd;
        logic [gpio_width-1:0] pin_exp;
        case (op)
            "W": write_reg(a[3:0], b);
            "R": begin
                read_reg(a[3:0], rd, ok);
                if (ok)
                    check_value($sformatf("reply of reg %h", a[3:0]), b, rd);
            end
            "I": begin
                pin_exp = (sh_dir & sh_out) | (~sh_dir & ext_in); // pad seen from inside
                read_reg(4'(reg_in), rd, ok);
                if (ok)
                    check_value("reply of reg 2", {4'b0000, pin_exp}, rd);
            end
            "D": begin
                check_value("gpio_out_en", {4'b0000, a[3:0]}, {4'b0000, gpio_out_en});
                check_value("gpio_out", {4'b0000, b[3:0]}, {4'b0000, gpio_out});
            end
            "Q": check_value("intr", {7'b0, a[0]}, {7'b0, intr});
            "P", "X": begin
                @(negedge clk);
                if (op == "P") begin
                    ext_in = a[3:0];
                end else begin
                    rnd    = $random(seed);
                    ext_in = (ext_in & ~a[3:0]) | (rnd[3:0] & a[3:0]); // only masked bits move
                end
                repeat (settle_clks) @(negedge clk);
            end
            default: begin
                $display("unknown opcode %c on stimulus entry %0d", op, line_no);
                other_errors++;
            end
        endcase
    endtask

    task automatic load_script();
        int         fd, n, code, a, b;
        string      line;
        logic [7:0] op;
        fd = $fopen("testbench/serial_gpio_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file testbench/serial_gpio_stimulus.txt");
            other_errors++;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                a    = 0;
                b    = 0;
                if (code > 0 && line.len() > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%c %h %h", op, a, b);
                    if (n >= 1 && op >= "A" && op <= "Z") begin // skips blank lines
                        op_q.push_back(op);
                        a_q.push_back(a[7:0]);
                        b_q.push_back(b[7:0]);
                    end
                end
            end
            $fclose(fd);
        end
        script_len = op_q.size();
    endtask

    initial begin
        int idx;
        seed         = 13347;
        check_errors = 0;
        other_errors = 0;
        loaded       = 1'b0;
        rst_n        = 1'b0;
        rxd          = 1'b1; // line idle
        ext_in       = '1;   // pull-ups
        sh_dir       = '0;
        sh_out       = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        check_value("txd", 8'h01, {7'b0, txd});
        check_value("intr", 8'h00, {7'b0, intr});
        check_value("gpio_out_en", 8'h00, {4'b0000, gpio_out_en});
        check_value("gpio_out", 8'h00, {4'b0000, gpio_out});
        load_script();
        if (script_len > 0)
            loaded = 1'b1; // arms the watchdog
        for (idx = 0; idx < script_len; idx++)
            run_line(idx + 1, op_q[idx], a_q[idx], b_q[idx]);
        $display("%0d entries run, %0d check errors, %0d other errors",
                 script_len, check_errors, other_errors);
        if (check_errors == 0 && other_errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    // watchdog sized at three frames per script entry
    initial begin
        wait (loaded === 1'b1);
        repeat (script_len * 3 * frame_clks) @(posedge clk);
        $display("timeout after %0d clocks, the script did not finish",
                 script_len * 3 * frame_clks);
        $display("Testbench failed");
        $finish;
    end

endmodule

// File: testbench/serial_gpio_stimulus.txt
# op a b (hex): W addr data | R addr expect | I read reg 2 vs pad model | D out_en out
# Q intr | P external pins | X random external bits under mask
R 0 00
R 5 00 undefined address
R f 00
I
W 0 a3 pins 1:0 driven low
R 0 03
W 1 5a
R 1 0a
D 3 a
I
R 3 03 bits 1:0 changed
W 3 0f
R 3 00
Q 0
W 4 f4
R 4 04
P b bit 2 falls
Q 1
R 3 04
I
W 3 04
Q 0
P 3 bit 3 falls but is masked
Q 0
R 3 08
X c
I
W 0 00
D 0 a
I
X f
I

// File: build.f
rtl/sergpio_pkg.sv
rtl/baud_timer.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/serial_cmd_fsm.sv
rtl/gpio_regs.sv
rtl/serial_gpio_top.sv
testbench/tb_clk_gen.sv
testbench/serial_gpio_chk.sv
testbench/serial_gpio_tb.sv

// File: Bender.yml
package:
  name: serial_gpio

sources:
  - files:
      - rtl/sergpio_pkg.sv
      - rtl/baud_timer.sv
      - rtl/uart_rx.sv
      - rtl/uart_tx.sv
      - rtl/serial_cmd_fsm.sv
      - rtl/gpio_regs.sv
      - rtl/serial_gpio_top.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/serial_gpio_chk.sv
      - testbench/serial_gpio_tb.sv
